/* Makefile */
# Verilator build and run for the bus-based CPU testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_TEXT := Test completed successfully

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_TEXT)"; then echo "run: PASS"; \
	else echo "run: FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/logicUnit.sv
verilog/arithUnit.sv
verilog/datapath.sv
verilog/controlSequencer.sv
verilog/cpuTop.sv
testbench/cpuTb.sv

/* testbench/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int ResetCycles = 8;
    localparam int LogicRounds = 4;
    localparam int ArithRounds = 3;
    localparam int MulRounds   = 5;
    // instructions issued by the sequence in the main initial block
    localparam int NumInstr = 11 + LogicRounds * 12 + ArithRounds * 8 + 6 + MulRounds * 7;
    localparam int CyclesPerInstr = int'(DONE) + 5;  // ack latency plus handshake and hold
    localparam int TimeoutCycles  = NumInstr * CyclesPerInstr + ResetCycles + 40;

    logic                 Clock;
    logic                 rst;
    logic                 req;
    logic                 ack;
    logic [WordWidth-1:0] instrWord;
    logic [WordWidth-1:0] inPort;
    logic [WordWidth-1:0] outPort;

    logic [WordWidth-1:0] regModel [16];  // R0 entry is never written
    logic [WordWidth-1:0] hiModel;
    logic [WordWidth-1:0] loModel;
    integer               seed;
    int                   cycleCount = 0;

    cpuTop dut0 (
        .Clock     (Clock),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .instrWord (instrWord),
        .inPort    (inPort),
        .outPort   (outPort)
    );

    initial Clock = 1'b0;
    always #10 Clock = ~Clock;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        stopRun($sformatf("ERR %0t %s expected %h got %h", $time, name, expected, actual));
    endtask

    function automatic logic [WordWidth-1:0] encode(input opcode_t op, input logic [3:0] ra,
                                                    input logic [3:0] rb, input logic [3:0] rc,
                                                    input logic [14:0] imm);
        logic [WordWidth-1:0] word;
        word = '0;
        word[OpcodeMsb:OpcodeLsb] = op;
        word[RaMsb:RaLsb]         = ra;
        word[RbMsb:RbLsb]         = rb;
        word[RcMsb:RcLsb]         = rc;
        word[ImmMsb:ImmLsb]       = imm;
        return word;
    endfunction

    // one instruction through the full req/ack cycle
    task automatic issue(input logic [WordWidth-1:0] word);
        int holdCycles;
        holdCycles = int'($unsigned($random(seed)) % 3);  // extra clocks with req held
        @(posedge Clock);
        #1;
        instrWord = word;
        req       = 1'b1;
        do begin
            @(posedge Clock);
            #1;
        end while (!ack);
        repeat (holdCycles) begin
            @(posedge Clock);
            #1;
        end
        req = 1'b0;
        do begin
            @(posedge Clock);
            #1;
        end while (ack);
    endtask

    task automatic loadReg(input logic [3:0] ra, input logic [WordWidth-1:0] value);
        inPort = value;
        issue(encode(IN, ra, 4'd0, 4'd0, 15'd0));
        if (ra != 4'd0) regModel[ra] = value;
    endtask

    task automatic loadImm(input logic [3:0] ra, input logic [14:0] imm);
        issue(encode(LDI, ra, 4'd0, 4'd0, imm));
        if (ra != 4'd0) regModel[ra] = {{(WordWidth - 15){imm[14]}}, imm};  // sign-extended
    endtask

    // Ra gets op(Rb, Rc); NOT and NEG only look at Rc
    task automatic runRegOp(input opcode_t op, input logic [3:0] ra, input logic [3:0] rb,
                            input logic [3:0] rc);
        logic [WordWidth-1:0]          b;
        logic [WordWidth-1:0]          c;
        logic [WordWidth-1:0]          result;
        logic signed [2*WordWidth-1:0] product;
        b = regModel[rb];
        c = regModel[rc];
        product = $signed({{WordWidth{b[WordWidth-1]}}, b})
                * $signed({{WordWidth{c[WordWidth-1]}}, c});
        case (op)
            ADD:     result = b + c;
            SUB:     result = b - c;
            AND:     result = b & c;
            OR:      result = b | c;
            NOT:     result = ~c;
            NEG:     result = -c;
            SHL:     result = b << c[4:0];
            SHR:     result = b >> c[4:0];
            default: result = '0;
        endcase
        issue(encode(op, ra, rb, rc, 15'd0));
        if (op == MUL) begin
            hiModel = product[2*WordWidth-1:WordWidth];
            loModel = product[WordWidth-1:0];
        end else if (ra != 4'd0) begin
            regModel[ra] = result;
        end
    endtask

    task automatic moveFrom(input opcode_t op, input logic [3:0] ra);
        issue(encode(op, ra, 4'd0, 4'd0, 15'd0));
        if (ra != 4'd0) regModel[ra] = (op == MFHI) ? hiModel : loModel;
    endtask

    task automatic outAndCheck(input logic [3:0] ra);
        logic [WordWidth-1:0] expected;
        expected = regModel[ra];
        issue(encode(OUT, ra, 4'd0, 4'd0, 15'd0));
        assert (outPort === expected)
            else reportMismatch("outPort", expected, outPort);
    endtask

    // sampled values trail the edge that sets them, so 7 clocks show up as ##8
    assert property (@(posedge Clock) disable iff (rst) $rose(req) |-> ##8 $rose(ack))
        else reportMismatch("ack", 32'd1, {31'd0, $sampled(ack)});

    assert property (@(posedge Clock) disable iff (rst) (ack && req) |=> ack)
        else reportMismatch("ack", 32'd1, {31'd0, $sampled(ack)});

    assert property (@(posedge Clock) disable iff (rst) (ack && !req) |=> !ack)
        else reportMismatch("ack", 32'd0, {31'd0, $sampled(ack)});

    // ack was set from the req seen one edge before its rise shows up
    assert property (@(posedge Clock) disable iff (rst) $rose(ack) |-> $past(req))
        else stopRun("ack rose while req was low");

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            stopRun($sformatf("timeout, run still busy after %0d clock cycles", TimeoutCycles));
        end
    end

    initial begin
        opcode_t logicOps [5];
        logic [WordWidth-1:0] valueA;
        logic [WordWidth-1:0] valueB;
        logicOps  = '{AND, OR, NOT, SHL, SHR};
        seed      = 32'h720e;
        rst       = 1'b1;
        req       = 1'b0;
        instrWord = '0;
        inPort    = '0;
        hiModel   = '0;
        loModel   = '0;
        for (int i = 0; i < 16; i++) begin
            regModel[i] = '0;
        end
        repeat (ResetCycles) @(posedge Clock);
        #1;
        rst = 1'b0;

        assert (ack === 1'b0) else reportMismatch("ack", 32'd0, {31'd0, ack});
        assert (outPort === '0) else reportMismatch("outPort", '0, outPort);
        outAndCheck(4'd5);  // never written

        loadImm(4'd1, 15'h1234);
        outAndCheck(4'd1);
        loadImm(4'd2, 15'h7ff0);  // negative immediate
        outAndCheck(4'd2);
        loadImm(4'd3, 15'($random(seed)));
        outAndCheck(4'd3);
        for (int i = 0; i < 2; i++) begin
            loadReg(4'd4, $random(seed));
            inPort = $random(seed);  // port moves on after the capture
            outAndCheck(4'd4);
        end

        for (int r = 0; r < LogicRounds; r++) begin
            loadReg(4'd6, $random(seed));
            loadReg(4'd7, $random(seed));
            for (int k = 0; k < 5; k++) begin
                runRegOp(logicOps[k], 4'd8, 4'd6, 4'd7);
                outAndCheck(4'd8);
            end
        end

        for (int r = 0; r < ArithRounds; r++) begin
            loadReg(4'd6, $random(seed));
            loadReg(4'd7, $random(seed));
            runRegOp(ADD, 4'd9, 4'd6, 4'd7);
            outAndCheck(4'd9);
            runRegOp(SUB, 4'd9, 4'd6, 4'd7);
            outAndCheck(4'd9);
            runRegOp(NEG, 4'd9, 4'd6, 4'd7);
            outAndCheck(4'd9);
        end
        loadImm(4'd0, 15'h0055);  // R0 stays zero
        outAndCheck(4'd0);
        runRegOp(ADD, 4'd9, 4'd0, 4'd6);
        outAndCheck(4'd9);
        runRegOp(SUB, 4'd9, 4'd6, 4'd0);
        outAndCheck(4'd9);

        for (int r = 0; r < MulRounds; r++) begin
            if (r == 0) begin
                valueA = 32'hffff_fffd;  // -3 times 5
                valueB = 32'd5;
            end else begin
                valueA = $random(seed);
                valueB = $random(seed);
            end
            loadReg(4'd12, valueA);
            loadReg(4'd13, valueB);
            runRegOp(MUL, 4'd0, 4'd12, 4'd13);
            moveFrom(MFHI, 4'd10);
            moveFrom(MFLO, 4'd11);
            outAndCheck(4'd10);
            outAndCheck(4'd11);
        end

        repeat (4) @(posedge Clock);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/arithUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module arithUnit (
    input  wire cpuPkg::opcode_t                aluOp,
    input  wire logic [cpuPkg::WordWidth-1:0]   yValue,
    input  wire logic [cpuPkg::WordWidth-1:0]   busValue,
    output logic      [2*cpuPkg::WordWidth-1:0] arithResult
);
    import cpuPkg::*;

    logic        [WordWidth-1:0]   addSum;
    logic        [WordWidth-1:0]   subDiff;
    logic        [WordWidth-1:0]   negValue;
    logic signed [2*WordWidth-1:0] product;

    assign addSum   = yValue + busValue;
    assign subDiff  = yValue - busValue;
    assign negValue = '0 - busValue;
    assign product  = $signed(yValue) * $signed(busValue);  // full width, signed

    always_comb begin
        case (aluOp)
            ADD: begin
                arithResult = {{WordWidth{addSum[WordWidth-1]}}, addSum};
            end
            SUB: begin
                arithResult = {{WordWidth{subDiff[WordWidth-1]}}, subDiff};
            end
            NEG: begin
                arithResult = {{WordWidth{negValue[WordWidth-1]}}, negValue};
            end
            MUL: begin
                arithResult = product;  // high half goes to HI later
            end
            default: begin
                arithResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/controlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire logic            Clock,
    input  wire logic            rst,
    input  wire logic            req,
    output logic                 ack,
    input  wire cpuPkg::opcode_t irOpcode,
    input  wire logic [3:0]      irRa,
    input  wire logic [3:0]      irRb,
    input  wire logic [3:0]      irRc,
    output cpuPkg::busSrc_t      busSrc,
    output logic      [3:0]      regSel,
    output logic                 regWrite,
    output logic                 marLoad,
    output logic                 pcLoad,
    output logic                 incPc,
    output logic                 mdrLoad,
    output logic                 irLoad,
    output logic                 yLoad,
    output logic                 zLoad,
    output logic                 hiLoad,
    output logic                 loLoad,
    output logic                 outLoad,
    output cpuPkg::opcode_t      aluOp
);
    import cpuPkg::*;

    phase_t phase;
    logic   regOp;

    assign regOp = irOpcode inside {ADD, SUB, AND, OR, SHL, SHR, NOT, NEG, MUL};

    always_ff @(posedge Clock) begin
        if (rst) begin
            phase <= IDLE;
            ack   <= 1'b0;
        end else begin
            case (phase)
                IDLE: if (req) phase <= T0;
                T0:   phase <= T1;
                T1:   phase <= T2;
                T2:   phase <= T3;
                T3:   phase <= T4;
                T4:   phase <= T5;
                T5:   phase <= DONE;
                DONE: begin
                    if (!ack) begin
                        ack <= req;  // ack only answers a live req
                        if (!req) phase <= IDLE;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        phase <= IDLE;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_comb begin
        busSrc   = NONE;
        regSel   = 4'd0;
        regWrite = 1'b0;
        marLoad  = 1'b0;
        pcLoad   = 1'b0;
        incPc    = 1'b0;
        mdrLoad  = 1'b0;
        irLoad   = 1'b0;
        yLoad    = 1'b0;
        zLoad    = 1'b0;
        hiLoad   = 1'b0;
        loLoad   = 1'b0;
        outLoad  = 1'b0;
        aluOp    = NOP;
        case (phase)
            T0: begin  // MAR <- PC, Z <- PC+1
                busSrc  = PC;
                marLoad = 1'b1;
                zLoad   = 1'b1;
                incPc   = 1'b1;
            end
            T1: begin
                busSrc  = ZLO;
                pcLoad  = 1'b1;
                mdrLoad = 1'b1;
            end
            T2: begin
                busSrc = MDR;
                irLoad = 1'b1;
            end
            T3: begin
                regSel = (regOp) ? irRb : irRa;
                case (irOpcode)
                    LDI:  busSrc = IMM;
                    IN:   busSrc = INPORT;
                    MFHI: busSrc = HI;
                    MFLO: busSrc = LO;
                    OUT, ADD, SUB, AND, OR, SHL, SHR, NOT, NEG, MUL: busSrc = REG;
                    default: busSrc = NONE;
                endcase
                yLoad    = regOp;
                outLoad  = (irOpcode == OUT);
                regWrite = irOpcode inside {LDI, IN, MFHI, MFLO};
            end
            T4: begin
                if (regOp) begin
                    busSrc = REG;
                    regSel = irRc;
                    zLoad  = 1'b1;
                    aluOp  = irOpcode;
                end
            end
            T5: begin
                if (irOpcode == MUL) begin
                    hiLoad = 1'b1;  // both halves leave Z in one cycle
                    loLoad = 1'b1;
                end else if (regOp) begin
                    busSrc   = ZLO;
                    regSel   = irRa;
                    regWrite = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assert property (@(posedge Clock) disable iff (rst) ack |-> phase == DONE)
        else $error("ack high outside DONE");

    // the register file cannot drive the bus and take it back in one cycle
    assert property (@(posedge Clock) disable iff (rst) !(regWrite && busSrc == REG))
        else $error("regWrite with register bus source");

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    parameter int WordWidth = 32;

    typedef enum logic [4:0] {
        LDI  = 5'd0,
        ADD  = 5'd3,
        SUB  = 5'd4,
        AND  = 5'd5,
        OR   = 5'd6,
        SHR  = 5'd7,
        SHL  = 5'd9,
        MUL  = 5'd15,
        NEG  = 5'd17,
        NOT  = 5'd18,
        IN   = 5'd22,
        OUT  = 5'd23,
        MFHI = 5'd24,
        MFLO = 5'd25,
        NOP  = 5'd26
    } opcode_t;

    typedef enum logic [3:0] {
        IDLE, T0, T1, T2, T3, T4, T5, DONE
    } phase_t;

    typedef enum logic [3:0] {
        NONE, REG, PC, MDR, ZLO, ZHI, HI, LO, INPORT, IMM
    } busSrc_t;

    // instruction field bit ranges
    parameter int OpcodeMsb = 31;
    parameter int OpcodeLsb = 27;
    parameter int RaMsb     = 26;
    parameter int RaLsb     = 23;
    parameter int RbMsb     = 22;
    parameter int RbLsb     = 19;
    parameter int RcMsb     = 18;
    parameter int RcLsb     = 15;
    parameter int ImmMsb    = 14;
    parameter int ImmLsb    = 0;

endpackage

`default_nettype wire

/* verilog/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire logic                         Clock,
    input  wire logic                         rst,
    input  wire logic                         req,
    output logic                              ack,
    input  wire logic [cpuPkg::WordWidth-1:0] instrWord,
    input  wire logic [cpuPkg::WordWidth-1:0] inPort,
    output logic      [cpuPkg::WordWidth-1:0] outPort
);
    import cpuPkg::*;

    busSrc_t    busSrc;
    opcode_t    aluOp;
    opcode_t    irOpcode;
    logic [3:0] regSel;
    logic [3:0] irRa;
    logic [3:0] irRb;
    logic [3:0] irRc;
    logic       regWrite;
    logic       marLoad;
    logic       pcLoad;
    logic       incPc;
    logic       mdrLoad;
    logic       irLoad;
    logic       yLoad;
    logic       zLoad;
    logic       hiLoad;
    logic       loLoad;
    logic       outLoad;

    controlSequencer seq0 (
        .Clock    (Clock),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .irOpcode (irOpcode),
        .irRa     (irRa),
        .irRb     (irRb),
        .irRc     (irRc),
        .busSrc   (busSrc),
        .regSel   (regSel),
        .regWrite (regWrite),
        .marLoad  (marLoad),
        .pcLoad   (pcLoad),
        .incPc    (incPc),
        .mdrLoad  (mdrLoad),
        .irLoad   (irLoad),
        .yLoad    (yLoad),
        .zLoad    (zLoad),
        .hiLoad   (hiLoad),
        .loLoad   (loLoad),
        .outLoad  (outLoad),
        .aluOp    (aluOp)
    );

    datapath dp0 (
        .Clock     (Clock),
        .rst       (rst),
        .busSrc    (busSrc),
        .regSel    (regSel),
        .regWrite  (regWrite),
        .marLoad   (marLoad),
        .pcLoad    (pcLoad),
        .incPc     (incPc),
        .mdrLoad   (mdrLoad),
        .irLoad    (irLoad),
        .yLoad     (yLoad),
        .zLoad     (zLoad),
        .hiLoad    (hiLoad),
        .loLoad    (loLoad),
        .outLoad   (outLoad),
        .aluOp     (aluOp),
        .instrWord (instrWord),
        .inPort    (inPort),
        .irOpcode  (irOpcode),
        .irRa      (irRa),
        .irRb      (irRb),
        .irRc      (irRc),
        .outPort   (outPort)
    );

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire logic                         Clock,
    input  wire logic                         rst,
    input  wire cpuPkg::busSrc_t              busSrc,
    input  wire logic [3:0]                   regSel,
    input  wire logic                         regWrite,
    input  wire logic                         marLoad,
    input  wire logic                         pcLoad,
    input  wire logic                         incPc,
    input  wire logic                         mdrLoad,
    input  wire logic                         irLoad,
    input  wire logic                         yLoad,
    input  wire logic                         zLoad,
    input  wire logic                         hiLoad,
    input  wire logic                         loLoad,
    input  wire logic                         outLoad,
    input  wire cpuPkg::opcode_t              aluOp,
    input  wire logic [cpuPkg::WordWidth-1:0] instrWord,
    input  wire logic [cpuPkg::WordWidth-1:0] inPort,
    output cpuPkg::opcode_t                   irOpcode,
    output logic      [3:0]                   irRa,
    output logic      [3:0]                   irRb,
    output logic      [3:0]                   irRc,
    output logic      [cpuPkg::WordWidth-1:0] outPort
);
    import cpuPkg::*;

    logic [WordWidth-1:0]   pcReg;
    logic [WordWidth-1:0]   marReg;
    logic [WordWidth-1:0]   mdrReg;
    logic [WordWidth-1:0]   irReg;
    logic [WordWidth-1:0]   yReg;
    logic [2*WordWidth-1:0] zReg;
    logic [WordWidth-1:0]   hiReg;
    logic [WordWidth-1:0]   loReg;
    logic [WordWidth-1:0]   busValue;
    logic [WordWidth-1:0]   regData;
    logic [WordWidth-1:0]   immExt;
    logic [WordWidth-1:0]   logicResult;
    logic [2*WordWidth-1:0] arithResult;
    logic [2*WordWidth-1:0] zNext;

    regFile regs0 (
        .Clock    (Clock),
        .rst      (rst),
        .regSel   (regSel),
        .regWrite (regWrite),
        .busIn    (busValue),
        .regData  (regData)
    );

    logicUnit logic0 (
        .aluOp       (aluOp),
        .yValue      (yReg),
        .busValue    (busValue),
        .logicResult (logicResult)
    );

    arithUnit arith0 (
        .aluOp       (aluOp),
        .yValue      (yReg),
        .busValue    (busValue),
        .arithResult (arithResult)
    );

    assign irOpcode = opcode_t'(irReg[OpcodeMsb:OpcodeLsb]);
    assign irRa     = irReg[RaMsb:RaLsb];
    assign irRb     = irReg[RbMsb:RbLsb];
    assign irRc     = irReg[RcMsb:RcLsb];
    assign immExt   = {{(WordWidth-ImmMsb-1){irReg[ImmMsb]}}, irReg[ImmMsb:ImmLsb]};

    always_comb begin
        case (busSrc)
            REG:     busValue = regData;
            PC:      busValue = pcReg;
            MDR:     busValue = mdrReg;
            ZLO:     busValue = zReg[WordWidth-1:0];
            ZHI:     busValue = zReg[2*WordWidth-1:WordWidth];
            HI:      busValue = hiReg;
            LO:      busValue = loReg;
            INPORT:  busValue = inPort;
            IMM:     busValue = immExt;
            default: busValue = '0;  // nobody drives the bus
        endcase
    end

    // arithmetic ops keep all 64 bits, logic ops are zero-extended
    always_comb begin
        if (incPc) begin
            zNext = {{WordWidth{1'b0}}, pcReg + WordWidth'(1)};
        end else if (aluOp inside {ADD, SUB, NEG, MUL}) begin
            zNext = arithResult;
        end else begin
            zNext = {{WordWidth{1'b0}}, logicResult};
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcReg   <= '0;
            irReg   <= '0;
            hiReg   <= '0;
            loReg   <= '0;
            outPort <= '0;
        end else begin
            if (pcLoad)  pcReg   <= busValue;
            if (irLoad)  irReg   <= busValue;
            if (hiLoad)  hiReg   <= zReg[2*WordWidth-1:WordWidth];  // straight from Z
            if (loLoad)  loReg   <= zReg[WordWidth-1:0];
            if (outLoad) outPort <= busValue;
        end
    end

    always_ff @(posedge Clock) begin
        if (marLoad) marReg <= busValue;
        if (mdrLoad) mdrReg <= instrWord;  // instruction word stands in for memory
        if (yLoad)   yReg   <= busValue;
        if (zLoad)   zReg   <= zNext;
    end

    assert property (@(posedge Clock) disable iff (rst)
        (hiLoad || loLoad) |-> (hiLoad && loLoad && irOpcode == MUL))
        else $error("HI/LO load outside a MUL");

    // by the IR load the fetch address sits in MAR and PC has moved past it
    assert property (@(posedge Clock) disable iff (rst)
        irLoad |-> (pcReg == marReg + WordWidth'(1)))
        else $error("PC not one past MAR at IR load");

endmodule

`default_nettype wire

/* verilog/logicUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module logicUnit (
    input  wire cpuPkg::opcode_t              aluOp,
    input  wire logic [cpuPkg::WordWidth-1:0] yValue,
    input  wire logic [cpuPkg::WordWidth-1:0] busValue,
    output logic      [cpuPkg::WordWidth-1:0] logicResult
);
    import cpuPkg::*;

    logic [4:0] shiftAmount;

    assign shiftAmount = busValue[4:0];  // only the low bits count

    always_comb begin
        case (aluOp)
            AND: begin
                logicResult = yValue & busValue;
            end
            OR: begin
                logicResult = yValue | busValue;
            end
            NOT: begin
                // same operand as NEG, the value on the bus in T4
                logicResult = ~busValue;
            end
            SHL: begin
                logicResult = yValue << shiftAmount;
            end
            SHR: begin
                logicResult = yValue >> shiftAmount;  // logical shift
            end
            default: begin
                logicResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic                         Clock,
    input  wire logic                         rst,
    input  wire logic [3:0]                   regSel,
    input  wire logic                         regWrite,
    input  wire logic [cpuPkg::WordWidth-1:0] busIn,
    output logic      [cpuPkg::WordWidth-1:0] regData
);
    import cpuPkg::*;

    localparam int RegCount = 16;

    logic [WordWidth-1:0] regs [RegCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && regSel != 4'd0) begin  // R0 is hardwired
            regs[regSel] <= busIn;
        end
    end

    // single read port onto the bus
    assign regData = (regSel == 4'd0) ? '0 : regs[regSel];

    // a write with an unknown select would corrupt an unknown register
    assert property (@(posedge Clock) disable iff (rst)
        regWrite |-> !$isunknown(regSel))
        else $error("regFile write with unknown regSel");

endmodule

`default_nettype wire
